//--- hw/dcache_pkg.sv
// Data cache maintenance package with geometry constants and shared vector types
package dcache_pkg;

    // ------------------------------------------------------------
    // Geometry
    // ------------------------------------------------------------
    // Four ways per set
    localparam int num_ways = 4;
    // 256 sets
    localparam int set_bits = 8;

    // ------------------------------------------------------------
    // Widths with a meaning
    // ------------------------------------------------------------
    // Byte address of a request or writeback
    typedef logic [31:0]  addr_t;
    // Set index, address bits 11 to 4
    typedef logic [7:0]   set_idx_t;
    // Line tag, address bits 31 to 12
    typedef logic [19:0]  tag_t;
    // One 16-byte line
    typedef logic [127:0] line_t;
    // Tag above line, as held per way
    typedef logic [147:0] way_entry_t;
    // Three pLRU bits above four MSI fields, way 0 lowest
    // MSI field: x0 invalid, 01 valid clean, 11 valid dirty
    typedef logic [10:0]  ctrl_word_t;
    // Way number
    typedef logic [1:0]   way_idx_t;
    // Walk position, set above way
    typedef logic [9:0]   walk_idx_t;

    // Control RAM FSM
    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_invd,
        ctrl_wbinvd
    } ctrl_state_t;

endpackage

//--- hw/simple_ram.sv
// Dual-port RAM with one synchronous write port and one registered read port
module simple_ram #(
    parameter int WIDTH      = 8,
    parameter int DEPTH_BITS = 8
) (
    input  logic                  clk,
    input  logic [DEPTH_BITS-1:0] wraddress,
    input  logic [DEPTH_BITS-1:0] rdaddress,
    input  logic                  wren,
    input  logic [WIDTH-1:0]      data,
    output logic [WIDTH-1:0]      q
);

    // Storage array
    logic [WIDTH-1:0] mem [2**DEPTH_BITS];

    // Write on the edge, read registered
    // Same-address read during write returns the old word
    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wraddress] <= data;
        end
        q <= mem[rdaddress];
    end

endmodule

//--- hw/dcache_line_store.sv
// Four-way tag and line storage with fill writes and a parallel read of all ways
module dcache_line_store (
    input  logic                   clk,

    // Fill port
    input  logic                   fill_do,
    input  dcache_pkg::way_idx_t   fill_way,
    input  dcache_pkg::addr_t      fill_address,
    input  dcache_pkg::line_t      fill_line,

    // Walk read port, data one cycle later
    input  dcache_pkg::set_idx_t   rd_address,
    output dcache_pkg::way_entry_t way0_q,
    output dcache_pkg::way_entry_t way1_q,
    output dcache_pkg::way_entry_t way2_q,
    output dcache_pkg::way_entry_t way3_q
);

    import dcache_pkg::*;

    // ------------------------------------------------------------
    // Fill entry
    // ------------------------------------------------------------
    tag_t       fill_tag;
    set_idx_t   fill_set;
    way_entry_t fill_entry;
    way_entry_t rd_q [num_ways];

    assign fill_tag   = fill_address[31:12];
    assign fill_set   = fill_address[11:4];
    // Tag sits above the line
    assign fill_entry = {fill_tag, fill_line};

    // ------------------------------------------------------------
    // One RAM per way
    // ------------------------------------------------------------
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        // Only the addressed way takes the fill
        simple_ram #(
            .WIDTH      ($bits(way_entry_t)),
            .DEPTH_BITS (set_bits)
        ) u_way_ram (
            .clk       (clk),
            .wraddress (fill_set),
            .rdaddress (rd_address),
            .wren      (fill_do && (fill_way == way_idx_t'(w))),
            .data      (fill_entry),
            .q         (rd_q[w])
        );
    end

    // All ways read at the same set
    assign way0_q = rd_q[0];
    assign way1_q = rd_q[1];
    assign way2_q = rd_q[2];
    assign way3_q = rd_q[3];

endmodule

//--- hw/dcache_control_ram.sv
// Per-set MSI and pLRU state RAM with reset clearing, INVD and the WBINVD walk
module dcache_control_ram (
    input  logic                   clk,
    input  logic                   rst_n,

    // Control word requests
    input  dcache_pkg::addr_t      address,
    input  dcache_pkg::ctrl_word_t data,
    output dcache_pkg::ctrl_word_t q,
    input  logic                   read_do,
    input  logic                   write_do,

    // Whole-cache maintenance
    input  logic                   invd_do,
    output logic                   invd_done,
    input  logic                   wbinvd_do,
    output logic                   wbinvd_done,

    // Line store read for the walk
    output logic                   wbinvdread_do,
    output dcache_pkg::set_idx_t   wbinvdread_address,
    input  dcache_pkg::way_entry_t way0_q,
    input  dcache_pkg::way_entry_t way1_q,
    input  dcache_pkg::way_entry_t way2_q,
    input  dcache_pkg::way_entry_t way3_q,

    // Dirty line out
    output logic                   writeline_do,
    input  logic                   writeline_done,
    output dcache_pkg::addr_t      writeline_address,
    output dcache_pkg::line_t      writeline_line
);

    import dcache_pkg::*;

    // ------------------------------------------------------------
    // Control state
    // ------------------------------------------------------------
    ctrl_state_t state;
    logic        init_done;
    logic        after_clear;
    set_idx_t    invd_cnt;
    walk_idx_t   walk_cnt;
    set_idx_t    last_set;

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    ctrl_word_t  ram_q;
    ctrl_word_t  ram_data;
    set_idx_t    ram_wraddr;
    set_idx_t    ram_rdaddr;
    logic        ram_wren;
    set_idx_t    req_set;
    set_idx_t    walk_set;
    way_idx_t    walk_way;
    walk_idx_t   walk_next;
    logic        clearing;
    logic        start_wbinvd;
    logic        req_wr;
    logic        walk_dirty;
    logic        walk_adv;
    logic        walk_wr;
    way_entry_t  walk_entry;

    assign req_set   = address[11:4];
    assign walk_set  = walk_cnt[9:2];
    assign walk_way  = walk_cnt[1:0];
    assign walk_next = walk_cnt + walk_idx_t'(1);

    // Reset pass and INVD both sweep with invd_cnt
    assign clearing     = !init_done || (state == ctrl_invd);
    // INVD wins over WBINVD when both arrive together
    assign start_wbinvd = init_done && (state == ctrl_idle) && !invd_do && wbinvd_do;
    assign req_wr       = init_done && (state == ctrl_idle) && !start_wbinvd && write_do;

    // Dirty test on the field of the current way
    assign walk_dirty = (ram_q[2*walk_way +: 2] == 2'b11);
    // Clean or invalid ways pass at once, dirty ones wait for the port
    assign walk_adv   = (state == ctrl_wbinvd) && (!walk_dirty || writeline_done);
    // Set is zeroed once its last way is handled
    assign walk_wr    = walk_adv && (walk_way == way_idx_t'(num_ways - 1));

    // Entry of the current way
    always_comb begin
        unique case (walk_way)
            2'd0:    walk_entry = way0_q;
            2'd1:    walk_entry = way1_q;
            2'd2:    walk_entry = way2_q;
            default: walk_entry = way3_q;
        endcase
    end

    // Read address moves only on advance, so entries stay put while stalled
    assign wbinvdread_do      = start_wbinvd || walk_adv;
    assign wbinvdread_address = walk_adv ? walk_next[9:2] : walk_set;

    // Writeback request held while the way is dirty
    assign writeline_do      = (state == ctrl_wbinvd) && walk_dirty;
    assign writeline_address = {walk_entry[147:128], walk_set, 4'd0};
    assign writeline_line    = walk_entry[127:0];

    // Completion pulses on the final count
    assign invd_done   = init_done && (state == ctrl_invd) && (invd_cnt == '1);
    assign wbinvd_done = walk_adv && (walk_cnt == '1);

    // Stale or busy reads show zero
    assign q = (!init_done || state != ctrl_idle || start_wbinvd || after_clear) ?
               '0 : ram_q;

    // ------------------------------------------------------------
    // RAM port muxing
    // ------------------------------------------------------------
    assign ram_wren   = clearing || walk_wr || req_wr;
    assign ram_wraddr = clearing ? invd_cnt :
                        (state == ctrl_wbinvd) ? walk_set : req_set;
    assign ram_data   = req_wr ? data : '0;
    assign ram_rdaddr = (start_wbinvd || state == ctrl_wbinvd) ? wbinvdread_address :
                        read_do ? req_set : last_set;

    simple_ram #(
        .WIDTH      ($bits(ctrl_word_t)),
        .DEPTH_BITS (set_bits)
    ) u_state_ram (
        .clk       (clk),
        .wraddress (ram_wraddr),
        .rdaddress (ram_rdaddr),
        .wren      (ram_wren),
        .data      (ram_data),
        .q         (ram_q)
    );

    // ------------------------------------------------------------
    // FSM and counters
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ctrl_idle;
            init_done   <= 1'b0;
            after_clear <= 1'b0;
            invd_cnt    <= '0;
            walk_cnt    <= '0;
            last_set    <= '0;
        end else begin
            // Idle re-reads the last requested set
            if (read_do) begin
                last_set <= req_set;
            end
            if (!init_done) begin
                // Clearing pass after reset
                invd_cnt <= invd_cnt + set_idx_t'(1);
                if (invd_cnt == '1) begin
                    init_done   <= 1'b1;
                    after_clear <= 1'b1;
                end
            end else begin
                unique case (state)
                    ctrl_idle: begin
                        after_clear <= 1'b0;
                        if (invd_do) begin
                            state <= ctrl_invd;
                        end else if (wbinvd_do) begin
                            state <= ctrl_wbinvd;
                        end
                    end
                    ctrl_invd: begin
                        invd_cnt <= invd_cnt + set_idx_t'(1);
                        if (invd_cnt == '1) begin
                            after_clear <= 1'b1;
                            state       <= ctrl_idle;
                        end
                    end
                    ctrl_wbinvd: begin
                        // Counter wraps to zero for the next walk
                        if (walk_adv) begin
                            walk_cnt <= walk_next;
                            if (walk_cnt == '1) begin
                                after_clear <= 1'b1;
                                state       <= ctrl_idle;
                            end
                        end
                    end
                    default: state <= ctrl_idle;
                endcase
            end
        end
    end

endmodule

//--- hw/dcache_writeback_port.sv
// Credit-counted writeback output stage driving the external line channel
module dcache_writeback_port #(
    parameter int WB_CREDITS = 2
) (
    input  logic              clk,
    input  logic              rst_n,

    // From the walk
    input  logic              writeline_do,
    output logic              writeline_done,
    input  dcache_pkg::addr_t writeline_address,
    input  dcache_pkg::line_t writeline_line,

    // External channel
    output logic              wb_valid,
    output dcache_pkg::addr_t wb_address,
    output dcache_pkg::line_t wb_line,
    input  logic              wb_credit
);

    localparam int CREDIT_BITS = $clog2(WB_CREDITS + 1);

    // Lines the receiver can still take
    logic [CREDIT_BITS-1:0] credits;

    // Accept whenever a credit is left
    assign writeline_done = writeline_do && (credits != '0);

    // ------------------------------------------------------------
    // Credit counter
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CREDIT_BITS'(WB_CREDITS);
        end else begin
            // Accept plus return in one cycle cancels out
            unique case ({writeline_done, wb_credit})
                2'b10:   credits <= credits - CREDIT_BITS'(1);
                2'b01:   credits <= credits + CREDIT_BITS'(1);
                default: credits <= credits;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Output beat
    // ------------------------------------------------------------
    // One-cycle valid after each acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= writeline_done;
        end
    end

    // Payload captured on acceptance
    always_ff @(posedge clk) begin
        if (writeline_done) begin
            wb_address <= writeline_address;
            wb_line    <= writeline_line;
        end
    end

endmodule

//--- hw/dcache_maint_top.sv
// Data cache maintenance top joining state RAM, line store and writeback port
module dcache_maint_top #(
    parameter int WB_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,

    // Control word requests
    input  logic                   read_do,
    input  logic                   write_do,
    input  dcache_pkg::addr_t      address,
    input  dcache_pkg::ctrl_word_t data,
    output dcache_pkg::ctrl_word_t q,

    // Line fills
    input  logic                   fill_do,
    input  dcache_pkg::way_idx_t   fill_way,
    input  dcache_pkg::addr_t      fill_address,
    input  dcache_pkg::line_t      fill_line,

    // Maintenance
    input  logic                   invd_do,
    output logic                   invd_done,
    input  logic                   wbinvd_do,
    output logic                   wbinvd_done,

    // Writeback channel
    output logic                   wb_valid,
    output dcache_pkg::addr_t      wb_address,
    output dcache_pkg::line_t      wb_line,
    input  logic                   wb_credit
);

    import dcache_pkg::*;

    // ------------------------------------------------------------
    // Inner nets
    // ------------------------------------------------------------
    set_idx_t   wbinvdread_address;
    way_entry_t way0_q;
    way_entry_t way1_q;
    way_entry_t way2_q;
    way_entry_t way3_q;
    logic       writeline_do;
    logic       writeline_done;
    addr_t      writeline_address;
    line_t      writeline_line;

    // Execute stage
    // Line store reads every cycle, so the read strobe stays open
    dcache_control_ram u_ctrl (
        .clk                (clk),
        .rst_n              (rst_n),
        .address            (address),
        .data               (data),
        .q                  (q),
        .read_do            (read_do),
        .write_do           (write_do),
        .invd_do            (invd_do),
        .invd_done          (invd_done),
        .wbinvd_do          (wbinvd_do),
        .wbinvd_done        (wbinvd_done),
        .wbinvdread_do      (),
        .wbinvdread_address (wbinvdread_address),
        .way0_q             (way0_q),
        .way1_q             (way1_q),
        .way2_q             (way2_q),
        .way3_q             (way3_q),
        .writeline_do       (writeline_do),
        .writeline_done     (writeline_done),
        .writeline_address  (writeline_address),
        .writeline_line     (writeline_line)
    );

    dcache_line_store u_lines (
        .clk          (clk),
        .fill_do      (fill_do),
        .fill_way     (fill_way),
        .fill_address (fill_address),
        .fill_line    (fill_line),
        .rd_address   (wbinvdread_address),
        .way0_q       (way0_q),
        .way1_q       (way1_q),
        .way2_q       (way2_q),
        .way3_q       (way3_q)
    );

    // Result stage
    dcache_writeback_port #(
        .WB_CREDITS (WB_CREDITS)
    ) u_wb (
        .clk               (clk),
        .rst_n             (rst_n),
        .writeline_do      (writeline_do),
        .writeline_done    (writeline_done),
        .writeline_address (writeline_address),
        .writeline_line    (writeline_line),
        .wb_valid          (wb_valid),
        .wb_address        (wb_address),
        .wb_line           (wb_line),
        .wb_credit         (wb_credit)
    );

endmodule

//--- verification/dcache_maint_assertions.sv
// Bound checks on the writeback port credits, line handshake and reset outputs
module dcache_maint_assertions #(
    parameter int WB_CREDITS = 2
) (
    input logic                                 clk,
    input logic                                 rst_n,
    input logic                                 writeline_do,
    input logic                                 writeline_done,
    input dcache_pkg::addr_t                    writeline_address,
    input dcache_pkg::line_t                    writeline_line,
    input logic                                 wb_valid,
    input logic [$clog2(WB_CREDITS + 1) - 1:0]  credits
);

    timeunit 1ns;
    timeprecision 100ps;

    // ------------------------------------------------------------
    // Credits
    // ------------------------------------------------------------
    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= WB_CREDITS)
        else $error("credit count above the configured limit");

    // A beat on the channel means its credit is already taken
    beat_holds_credit: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> credits < WB_CREDITS)
        else $error("writeback beat while every credit is still free");

    // ------------------------------------------------------------
    // Inner handshake
    // ------------------------------------------------------------
    // Request and payload held while stalled
    request_held: assert property (@(posedge clk) disable iff (!rst_n)
        writeline_do && !writeline_done |=>
            writeline_do && $stable(writeline_address) && $stable(writeline_line))
        else $error("writeline request dropped or changed before acceptance");

    // ------------------------------------------------------------
    // Output beat
    // ------------------------------------------------------------
    // One beat one cycle after each accepted line
    beat_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        writeline_done |=> wb_valid)
        else $error("accepted line produced no writeback beat");

    beat_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        !writeline_done |=> !wb_valid)
        else $error("writeback beat without an accepted line");

    // Outputs quiet right out of reset
    quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_valid && !writeline_do)
        else $error("writeback outputs active right after reset");

endmodule

bind dcache_writeback_port dcache_maint_assertions #(
    .WB_CREDITS (WB_CREDITS)
) u_assertions (
    .clk               (clk),
    .rst_n             (rst_n),
    .writeline_do      (writeline_do),
    .writeline_done    (writeline_done),
    .writeline_address (writeline_address),
    .writeline_line    (writeline_line),
    .wb_valid          (wb_valid),
    .credits           (credits)
);

//--- verification/dcache_maint_tb.sv
// Testbench for the cache maintenance top with a writeback reference model and credit return
module dcache_maint_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_pkg::*;

    localparam int credit_limit    = 2;
    localparam int maint_tests     = 4;
    localparam int walk_limit      = 1024 * 8;
    localparam int watchdog_cycles = maint_tests * (256 + walk_limit) + 4000;

    // ------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------
    logic       clk;
    logic       rst_n;
    logic       read_do;
    logic       write_do;
    addr_t      address;
    ctrl_word_t data;
    ctrl_word_t q;
    logic       fill_do;
    way_idx_t   fill_way;
    addr_t      fill_address;
    line_t      fill_line;
    logic       invd_do;
    logic       invd_done;
    logic       wbinvd_do;
    logic       wbinvd_done;
    logic       wb_valid;
    addr_t      wb_address;
    line_t      wb_line;
    logic       wb_credit;

    // Reference state
    ctrl_word_t ctrl_shadow [256];
    tag_t       tag_shadow  [256][num_ways];
    line_t      line_shadow [256][num_ways];
    addr_t      exp_addr [$];
    line_t      exp_line [$];

    logic [31:0] rng_stim   = 32'h4ad;
    logic [31:0] rng_credit = 32'h4ad;
    int          errors     = 0;
    int          checks     = 0;
    // Beats seen but not yet credited
    int          owed       = 0;
    bit          throttle   = 1'b0;
    int unsigned phase_cnt  = 0;
    string       test_name  = "reset";

    dcache_maint_top #(
        .WB_CREDITS (credit_limit)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .read_do      (read_do),
        .write_do     (write_do),
        .address      (address),
        .data         (data),
        .q            (q),
        .fill_do      (fill_do),
        .fill_way     (fill_way),
        .fill_address (fill_address),
        .fill_line    (fill_line),
        .invd_do      (invd_do),
        .invd_done    (invd_done),
        .wbinvd_do    (wbinvd_do),
        .wbinvd_done  (wbinvd_done),
        .wb_valid     (wb_valid),
        .wb_address   (wb_address),
        .wb_line      (wb_line),
        .wb_credit    (wb_credit)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] rand32();
        rng_stim = xorshift(rng_stim);
        return rng_stim;
    endfunction

    task automatic check_value(input string name, input logic [147:0] expected,
                               input logic [147:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Dirty fields only, ascending set then way
    function automatic void expected_writebacks();
        exp_addr.delete();
        exp_line.delete();
        for (int s = 0; s < 256; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                if (ctrl_shadow[s][2*w +: 2] == 2'b11) begin
                    exp_addr.push_back({tag_shadow[s][w], set_idx_t'(s), 4'h0});
                    exp_line.push_back(line_shadow[s][w]);
                end
            end
        end
    endfunction

    function automatic void clear_shadow();
        for (int s = 0; s < 256; s++) begin
            ctrl_shadow[s] = '0;
        end
    endfunction

    task automatic write_word(input set_idx_t s, input ctrl_word_t w);
        @(posedge clk);
        write_do <= 1'b1;
        address  <= {20'h0, s, 4'h0};
        data     <= w;
        @(posedge clk);
        write_do <= 1'b0;
    endtask

    // q sampled mid-cycle, one cycle after read_do
    task automatic read_word(input set_idx_t s, output ctrl_word_t w);
        @(posedge clk);
        read_do <= 1'b1;
        address <= {20'h0, s, 4'h0};
        @(posedge clk);
        read_do <= 1'b0;
        @(negedge clk);
        w = q;
    endtask

    task automatic fill_entry(input set_idx_t s, input way_idx_t w, input tag_t t,
                              input line_t l);
        @(posedge clk);
        fill_do      <= 1'b1;
        fill_way     <= w;
        fill_address <= {t, s, 4'h0};
        fill_line    <= l;
        @(posedge clk);
        fill_do <= 1'b0;
    endtask

    task automatic check_all_zero(input string name);
        ctrl_word_t rd;
        for (int s = 0; s < 256; s++) begin
            read_word(set_idx_t'(s), rd);
            check_value(name, '0, rd);
        end
    endtask

    task automatic wait_for_done(input bit use_wbinvd, input int limit, input string name);
        int  n;
        bit  seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < limit) begin
            @(negedge clk);
            seen = use_wbinvd ? wbinvd_done : invd_done;
            n++;
        end
        if (!seen) begin
            errors++;
            $display("Timeout in %s: no completion pulse within %0d cycles", name, limit);
        end
    endtask

    // Random tag and line in every way, random MSI and pLRU per set
    task automatic load_random_cache();
        logic [31:0] r;
        for (int s = 0; s < 256; s++) begin
            for (int w = 0; w < num_ways; w++) begin
                r = rand32();
                tag_shadow[s][w]  = r[19:0];
                line_shadow[s][w] = {rand32(), rand32(), rand32(), rand32()};
                fill_entry(set_idx_t'(s), way_idx_t'(w), tag_shadow[s][w], line_shadow[s][w]);
            end
        end
        for (int s = 0; s < 256; s++) begin
            r = rand32();
            ctrl_shadow[s] = r[10:0];
            write_word(set_idx_t'(s), r[10:0]);
        end
    endtask

    task automatic run_wbinvd(input string name, input bit use_throttle, input bit probe);
        ctrl_word_t rd;
        logic [31:0] r;
        int          n;
        test_name = name;
        expected_writebacks();
        @(negedge clk);
        throttle = use_throttle;
        @(posedge clk);
        wbinvd_do <= 1'b1;
        @(posedge clk);
        wbinvd_do <= 1'b0;
        if (probe) begin
            // Requests while the walk runs are ignored
            for (int i = 0; i < 8; i++) begin
                r = rand32();
                write_word(r[7:0], 11'h7ff);
                read_word(r[7:0], rd);
                check_value({name, " busy read"}, '0, rd);
            end
        end
        wait_for_done(1'b1, walk_limit, name);
        repeat (4) @(posedge clk);
        check_value({name, " beats missing"}, 0, exp_addr.size());
        // Drain outstanding credits
        @(negedge clk);
        throttle = 1'b0;
        n = 0;
        while (owed != 0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (owed != 0) begin
            errors++;
            $display("Credits for %s were never returned", name);
        end
        clear_shadow();
        check_all_zero({name, " clear"});
    endtask

    // ------------------------------------------------------------
    // Beat comparison
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            owed = owed + 1;
            if (owed > credit_limit) begin
                errors++;
                $display("More than %0d writeback beats outstanding in %s",
                         credit_limit, test_name);
            end
            if (exp_addr.size() == 0) begin
                errors++;
                $display("Unexpected writeback beat at %h in %s", wb_address, test_name);
            end else begin
                check_value({test_name, " wb_address"}, exp_addr.pop_front(), wb_address);
                check_value({test_name, " wb_line"}, exp_line.pop_front(), wb_line);
            end
        end
    end

    // ------------------------------------------------------------
    // Credit return
    // ------------------------------------------------------------
    always @(negedge clk) begin
        phase_cnt <= phase_cnt + 1;
    end

    // 0 to 6 cycles per credit, held back 24 of every 32 cycles when throttled
    initial begin
        int delay;
        forever begin
            @(posedge clk);
            if (owed > 0 && !(throttle && ((phase_cnt % 32) < 24))) begin
                rng_credit = xorshift(rng_credit);
                delay = rng_credit % 7;
                repeat (delay) @(posedge clk);
                wb_credit <= 1'b1;
                owed = owed - 1;
                @(posedge clk);
                wb_credit <= 1'b0;
            end
        end
    end

    // Watchdog
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with tests still running", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        ctrl_word_t  w;
        ctrl_word_t  rd;
        logic [31:0] r;
        logic [31:0] saved_rng;
        rst_n        = 1'b0;
        read_do      = 1'b0;
        write_do     = 1'b0;
        address      = '0;
        data         = '0;
        fill_do      = 1'b0;
        fill_way     = '0;
        fill_address = '0;
        fill_line    = '0;
        invd_do      = 1'b0;
        wbinvd_do    = 1'b0;
        wb_credit    = 1'b0;
        clear_shadow();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Clearing pass, then read and write back
        test_name = "reset_clear";
        repeat (256 + 4) @(posedge clk);
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            read_word(r[7:0], rd);
            check_value(test_name, '0, rd);
        end
        test_name = "write_read";
        for (int i = 0; i < 16; i++) begin
            r = rand32();
            w = r[18:8];
            write_word(r[7:0], w);
            ctrl_shadow[r[7:0]] = w;
            read_word(r[7:0], rd);
            check_value(test_name, w, rd);
        end

        // INVD over dirty sets, no beats expected
        test_name = "invd";
        for (int i = 0; i < 32; i++) begin
            r = rand32();
            write_word(r[7:0], {r[10:8], 8'hff});
        end
        @(posedge clk);
        invd_do <= 1'b1;
        @(posedge clk);
        invd_do <= 1'b0;
        wait_for_done(1'b0, 256 + 16, test_name);
        clear_shadow();
        check_all_zero("invd clear");

        // Same cache image for the plain and throttled walks
        saved_rng = rng_stim;
        load_random_cache();
        run_wbinvd("wbinvd", 1'b0, 1'b0);
        rng_stim = saved_rng;
        load_random_cache();
        run_wbinvd("wbinvd_backpressure", 1'b1, 1'b0);

        load_random_cache();
        run_wbinvd("wbinvd_busy", 1'b0, 1'b1);

        $display("Closing summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
hw/dcache_pkg.sv
hw/simple_ram.sv
hw/dcache_line_store.sv
hw/dcache_control_ram.sv
hw/dcache_writeback_port.sv
hw/dcache_maint_top.sv
verification/dcache_maint_assertions.sv
verification/dcache_maint_tb.sv

//--- Bender.yml
package:
  name: dcache_maint

sources:
  - target: rtl
    files:
      - hw/dcache_pkg.sv
      - hw/simple_ram.sv
      - hw/dcache_line_store.sv
      - hw/dcache_control_ram.sv
      - hw/dcache_writeback_port.sv
      - hw/dcache_maint_top.sv
  - target: test
    files:
      - verification/dcache_maint_assertions.sv
      - verification/dcache_maint_tb.sv
